/* Makefile */
VERILATOR ?= verilator
TOP       ?= fu_cluster_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_TEXT ?= PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* alu_unit.sv */
module alu_unit import fu_pkg::*; (
  input  alu_func_t func,
  input  word_t     opa,
  input  word_t     opb,
  output word_t     result
);

  logic [$clog2(word_w)-1:0] shamt;
  logic                      lt_u;
  logic                      lt_s;
  logic                      eq;

  assign shamt = opb[$clog2(word_w)-1:0];
  assign lt_u  = opa < opb;
  assign lt_s  = $signed(opa) < $signed(opb);
  assign eq    = opa == opb;

  always_comb begin
    case (func)
      ALU_ADDQ:   result = opa + opb;
      ALU_SUBQ:   result = opa - opb;
      ALU_AND:    result = opa & opb;
      ALU_BIC:    result = opa & ~opb;
      ALU_BIS:    result = opa | opb;
      ALU_ORNOT:  result = opa | ~opb;
      ALU_XOR:    result = opa ^ opb;
      ALU_EQV:    result = opa ^ ~opb;
      ALU_SRL:    result = opa >> shamt;
      ALU_SLL:    result = opa << shamt;
      ALU_SRA:    result = word_t'($signed(opa) >>> shamt);  // Sign fill
      ALU_CMPULT: result = word_t'(lt_u);
      ALU_CMPEQ:  result = word_t'(eq);
      ALU_CMPULE: result = word_t'(lt_u || eq);
      ALU_CMPLT:  result = word_t'(lt_s);
      ALU_CMPLE:  result = word_t'(lt_s || eq);
      default:    result = '0;
    endcase
  end

endmodule

/* branch_unit.sv */
module branch_unit import fu_pkg::*; (
  input  fu_op_t op,
  input  word_t  a,
  input  word_t  b,
  input  word_t  opa,
  input  word_t  opb,
  output logic   taken,
  output word_t  link,
  output word_t  target
);

  logic cond;
  logic is_zero;
  logic is_neg;

  assign is_zero = a == '0;
  assign is_neg  = a[word_w-1];

  // Base condition, shared by a branch and its negation
  always_comb begin
    case (op)
      BLBC, BLBS: cond = ~a[0];
      BEQ, BNE:   cond = is_zero;
      BLT, BGE:   cond = is_neg;
      BLE, BGT:   cond = is_neg || is_zero;
      default:    cond = 1'b0;
    endcase
  end

  always_comb begin
    case (op)
      BLBC, BEQ, BLT, BLE: taken = cond;
      BLBS, BNE, BGE, BGT: taken = ~cond;
      BR, JMP:             taken = 1'b1;
      default:             taken = 1'b0;
    endcase
  end

  assign link = opa;  // NPC

  // JMP goes through the register, aligned
  assign target = (op == JMP) ? {b[word_w-1:2], 2'b00} : opa + opb;

endmodule

/* cdb_driver.sv */
module cdb_driver import fu_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     load,
  input  logic     is_branch,
  input  word_t    alu_result,
  input  word_t    link,
  input  logic     taken,
  input  word_t    target,
  input  rob_idx_t rob,
  input  logic     sc_stall,
  output logic     sc_ready,
  output logic     sc_valid,
  output word_t    sc_result,
  output rob_idx_t sc_rob,
  output logic     rollback_valid,
  output rob_idx_t rollback_rob,
  output word_t    rollback_target
);

  logic do_load;

  assign sc_ready = !sc_valid || !sc_stall;  // Empty or draining this cycle
  assign do_load  = load && sc_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      sc_valid       <= 1'b0;
      rollback_valid <= 1'b0;
    end else begin
      if (sc_ready) begin
        sc_valid <= load;
      end
      rollback_valid <= do_load && is_branch && taken;  // Single cycle pulse
    end
  end

  always_ff @(posedge clock) begin
    if (do_load) begin
      sc_result       <= is_branch ? link : alu_result;
      sc_rob          <= rob;
      rollback_rob    <= rob;
      rollback_target <= target;
    end
  end

endmodule

/* fu_cluster.sv */
module fu_cluster import fu_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     issue_valid,
  input  fu_op_t   issue_op,
  input  word_t    issue_a,
  input  word_t    issue_b,
  input  word_t    issue_npc,
  input  lit_t     issue_lit,
  input  logic     issue_use_lit,
  input  disp_t    issue_disp,
  input  rob_idx_t issue_rob,
  input  rob_idx_t rob_head,
  input  logic     sc_stall,
  input  logic     mult_stall,
  output logic     issue_ready,
  output logic     sc_valid,
  output word_t    sc_result,
  output rob_idx_t sc_rob,
  output logic     mult_valid,
  output word_t    mult_result,
  output rob_idx_t mult_rob,
  output logic     rollback_valid,
  output rob_idx_t rollback_rob,
  output word_t    rollback_target
);

  unit_t     unit;
  alu_func_t func;
  word_t     opa;
  word_t     opb;
  word_t     alu_result;
  logic      taken;
  word_t     link;
  word_t     target;
  logic      sc_ready;
  logic      mult_ready;
  logic      accept;

  operand_decode decode_i (
    .op      (issue_op),
    .a       (issue_a),
    .b       (issue_b),
    .lit     (issue_lit),
    .use_lit (issue_use_lit),
    .npc     (issue_npc),
    .disp    (issue_disp),
    .unit    (unit),
    .func    (func),
    .opa     (opa),
    .opb     (opb)
  );

  alu_unit alu_i (
    .func   (func),
    .opa    (opa),
    .opb    (opb),
    .result (alu_result)
  );

  branch_unit branch_i (
    .op     (issue_op),
    .a      (issue_a),
    .b      (issue_b),
    .opa    (opa),
    .opb    (opb),
    .taken  (taken),
    .link   (link),
    .target (target)
  );

  // Multiplies wait on the pipeline, everything else on the result register
  assign issue_ready = (unit == UNIT_MULT) ? mult_ready : sc_ready;
  assign accept      = issue_valid && issue_ready;

  mult_pipeline mult_i (
    .clock          (clock),
    .reset          (reset),
    .start          (accept && unit == UNIT_MULT),
    .opa            (opa),
    .opb            (opb),
    .rob            (issue_rob),
    .rob_head       (rob_head),
    .rollback_valid (rollback_valid),
    .rollback_rob   (rollback_rob),
    .mult_stall     (mult_stall),
    .mult_ready     (mult_ready),
    .mult_valid     (mult_valid),
    .mult_result    (mult_result),
    .mult_rob       (mult_rob)
  );

  cdb_driver cdb_i (
    .clock           (clock),
    .reset           (reset),
    .load            (accept && unit != UNIT_MULT),
    .is_branch       (unit == UNIT_BR),
    .alu_result      (alu_result),
    .link            (link),
    .taken           (taken),
    .target          (target),
    .rob             (issue_rob),
    .sc_stall        (sc_stall),
    .sc_ready        (sc_ready),
    .sc_valid        (sc_valid),
    .sc_result       (sc_result),
    .sc_rob          (sc_rob),
    .rollback_valid  (rollback_valid),
    .rollback_rob    (rollback_rob),
    .rollback_target (rollback_target)
  );

endmodule

/* fu_cluster_tb.sv */
module fu_cluster_tb import fu_pkg::*; ();

  localparam int max_rows = 96;

  logic clock, reset, issue_valid, issue_use_lit, sc_stall, mult_stall;
  fu_op_t issue_op;
  word_t issue_a, issue_b, issue_npc, sc_result, mult_result, rollback_target;
  lit_t issue_lit;
  disp_t issue_disp;
  rob_idx_t issue_rob, rob_head, sc_rob, mult_rob, rollback_rob;
  logic issue_ready, sc_valid, mult_valid, rollback_valid;

  // Stimulus table
  fu_op_t r_op [max_rows];
  word_t r_a [max_rows], r_b [max_rows], r_npc [max_rows], r_value [max_rows], r_target [max_rows];
  lit_t r_lit [max_rows];
  disp_t r_disp [max_rows];
  rob_idx_t r_rob [max_rows];
  logic r_use_lit [max_rows], r_mult [max_rows], r_rb [max_rows];
  logic r_squash [max_rows], r_calm [max_rows];
  int n_rows;

  word_t sc_q_val[$], mult_q_val[$], rb_q_target[$];
  rob_idx_t sc_q_rob[$], mult_q_rob[$], rb_q_rob[$];
  int mult_q_cyc[$];
  logic mult_q_calm[$];
  int cycle, errors, checks;
  logic calm;

  tb_clock_gen clock_i (.clock(clock), .reset(reset));

  fu_cluster fu_cluster_i (.*);

  function automatic word_t expect_alu(fu_op_t op, word_t x, word_t y);
    logic [5:0] s;
    word_t sx, sy;
    s  = y[5:0];
    sx = x ^ {1'b1, 63'd0};  // Flip sign to compare signed as unsigned
    sy = y ^ {1'b1, 63'd0};
    case (op)
      ADDQ:    return x + y;
      SUBQ:    return x + ~y + 64'd1;
      AND:     return x & y;
      BIC:     return x & ~y;
      BIS:     return x | y;
      ORNOT:   return x | ~y;
      XOR:     return x ^ y;
      EQV:     return ~(x ^ y);
      SRL:     return x >> s;
      SLL:     return x << s;
      SRA:     return (x >> s) | (x[63] ? ~(~64'd0 >> s) : 64'd0);
      CMPULT:  return {63'd0, x < y};
      CMPEQ:   return {63'd0, x == y};
      CMPULE:  return {63'd0, x <= y};
      CMPLT:   return {63'd0, sx < sy};
      CMPLE:   return {63'd0, sx <= sy};
      default: return 64'd0;
    endcase
  endfunction

  function automatic logic expect_taken(fu_op_t op, word_t a);
    case (op)
      BLBC:    return !a[0];
      BLBS:    return a[0];
      BEQ:     return a == 0;
      BNE:     return a != 0;
      BLT:     return a[63];
      BGE:     return !a[63];
      BLE:     return a[63] || a == 0;
      BGT:     return !a[63] && a != 0;
      default: return 1'b1;
    endcase
  endfunction

  task automatic add_row(fu_op_t op, word_t a, word_t b, lit_t lit, logic use_lit,
                         word_t npc, disp_t disp, rob_idx_t rob, logic squash, logic quiet);
    int k;
    k = n_rows;
    r_op[k] = op;
    r_a[k] = a;
    r_b[k] = b;
    r_lit[k] = lit;
    r_use_lit[k] = use_lit;
    r_npc[k] = npc;
    r_disp[k] = disp;
    r_rob[k] = rob;
    r_squash[k] = squash;
    r_calm[k] = quiet;
    r_mult[k] = op == MULQ;
    r_rb[k] = op >= BLBC && expect_taken(op, a);
    r_target[k] = op == JMP ? b & ~64'd3 : npc + 64'($signed(disp)) * 64'd4;
    if (op == MULQ) r_value[k] = a * (use_lit ? {56'd0, lit} : b);
    else if (op >= BLBC) r_value[k] = npc;
    else r_value[k] = expect_alu(op, a, use_lit ? {56'd0, lit} : b);
    n_rows++;
  endtask

  task automatic compare_word(string name, word_t expected, word_t actual);
    checks++;
    assert (expected == actual) else begin
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic build_table();
    word_t x;
    for (int k = 0; k < 4; k++)  // Back-to-back multiplies, exact latency
      add_row(MULQ, 64'h1234_5678_9abc_def1 + k, 64'hfedc_ba98_0000_0003 * (k + 1), 0, 0, 0, 0,
              rob_idx_t'(3 + k), 0, 1);
    x = 64'h0000_0000_0010_0000;
    add_row(BLBC, 64'd2, 0, 0, 0, x, 21'd16, 27, 0, 1);
    add_row(BEQ, 64'd5, 0, 0, 0, x, 21'd8, 27, 0, 1);
    add_row(BLT, -64'd1, 0, 0, 0, x, -21'd4, 27, 0, 1);
    add_row(BLE, 64'd0, 0, 0, 0, x, 21'h0fffff, 27, 0, 1);
    add_row(BLBS, 64'd2, 0, 0, 0, x, 21'd3, 27, 0, 1);
    add_row(BNE, 64'd5, 0, 0, 0, x, 21'h100000, 27, 0, 1);
    add_row(BGE, -64'd3, 0, 0, 0, x, 21'd7, 27, 0, 1);
    add_row(BGT, 64'd7, 0, 0, 0, x, -21'd9, 27, 0, 1);
    add_row(BR, 64'd0, 0, 0, 0, x, 21'd100, 27, 0, 1);
    add_row(JMP, 64'd0, 64'h0000_4000_0000_1237, 0, 0, x, 21'd5, 27, 0, 1);
    // Head is 28, branch 31 sits at distance 3, index 0 at distance 4
    add_row(MULQ, 64'd1000, 64'd3, 0, 0, 0, 0, 29, 0, 1);
    add_row(MULQ, 64'd77, 64'd5, 0, 0, 0, 0, 0, 1, 1);
    add_row(MULQ, 64'd11, 0, 8'd9, 1, 0, 0, 30, 0, 1);
    add_row(BEQ, 64'd0, 0, 0, 0, 64'h2000, 21'd40, 31, 0, 1);
    for (int k = 0; k < 16; k++) begin
      add_row(fu_op_t'(k), 64'hffff_ffff_ffff_fff0, 64'h13, 8'h05, 0, 0, 0, rob_idx_t'(k), 0, 0);
      add_row(fu_op_t'(k), 64'h8000_0000_0000_0abc, 64'h7, 8'hc4, 1, 0, 0, rob_idx_t'(k), 0, 0);
    end
    for (int k = 0; k < 8; k++)
      add_row(fu_op_t'($urandom % 16), {$urandom, $urandom}, {$urandom, $urandom}, 8'($urandom),
              1'($urandom), 0, 0, rob_idx_t'(k), 0, 0);
    for (int k = 0; k < 8; k++) begin
      add_row(MULQ, {$urandom, $urandom}, {$urandom, $urandom}, 0, 0, 0, 0,
              rob_idx_t'(8 + k), 0, 0);
      add_row(k % 2 ? BNE : ADDQ, 64'd1, 64'd2, 0, 0, 64'h500, 21'd6, 27, 0, 0);
    end
  endtask

  always @(posedge clock) begin
    cycle <= cycle + 1;
    if (cycle > 20 * n_rows + 100) begin
      $display("Timeout after %0d cycles with results still outstanding", cycle);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  always @(posedge clock) begin
    #1;
    sc_stall   = calm ? 1'b0 : ($urandom % 3 == 0);
    mult_stall = calm ? 1'b0 : ($urandom % 3 == 0);
  end

  // Result monitors, sampling before the edge updates
  always @(posedge clock) begin
    if (!reset && sc_valid && !sc_stall) begin
      assert (sc_q_val.size() != 0) else begin
        $display("Unexpected result on the single-cycle port at %0t", $time);
        errors++;
      end
      if (sc_q_val.size() != 0) begin
        compare_word("sc_result", sc_q_val.pop_front(), sc_result);
        compare_word("sc_rob", word_t'(sc_q_rob.pop_front()), word_t'(sc_rob));
      end
    end
    if (!reset && mult_valid && !mult_stall) begin
      assert (mult_q_val.size() != 0) else begin
        $display("Unexpected result on the multiply port at %0t", $time);
        errors++;
      end
      if (mult_q_val.size() != 0) begin
        compare_word("mult_result", mult_q_val.pop_front(), mult_result);
        compare_word("mult_rob", word_t'(mult_q_rob.pop_front()), word_t'(mult_rob));
        if (mult_q_calm.pop_front())  // Consumed mult_stages edges after acceptance
          compare_word("mult_latency", word_t'(mult_stages),
                       word_t'(cycle - mult_q_cyc[0]));
        void'(mult_q_cyc.pop_front());
      end
    end
    if (!reset && rollback_valid) begin
      assert (rb_q_target.size() != 0) else begin
        $display("Rollback pulse at %0t with no taken branch pending", $time);
        errors++;
      end
      if (rb_q_target.size() != 0) begin
        compare_word("rollback_target", rb_q_target.pop_front(), rollback_target);
        compare_word("rollback_rob", word_t'(rb_q_rob.pop_front()), word_t'(rollback_rob));
      end
    end
  end

  initial begin
    void'($urandom(32'h2fa7));
    cycle = 0;
    errors = 0;
    checks = 0;
    calm = 1'b1;
    n_rows = 0;
    {issue_valid, issue_use_lit, sc_stall, mult_stall} = '0;
    {issue_a, issue_b, issue_npc, issue_lit, issue_disp, issue_rob} = '0;
    issue_op = ADDQ;
    rob_head = 5'd28;
    build_table();
    @(negedge reset);
    @(posedge clock);
    compare_word("sc_valid", 0, word_t'(sc_valid));
    compare_word("mult_valid", 0, word_t'(mult_valid));
    compare_word("rollback_valid", 0, word_t'(rollback_valid));
    compare_word("issue_ready", 1, word_t'(issue_ready));
    #2;
    for (int i = 0; i < n_rows; i++) begin
      if (calm && !r_calm[i]) begin
        issue_valid = 1'b0;  // Timed multiplies finish before random stall starts
        while (mult_q_val.size() != 0) begin
          @(posedge clock);
          #2;
        end
      end
      issue_op = r_op[i];
      issue_a = r_a[i];
      issue_b = r_b[i];
      issue_lit = r_lit[i];
      issue_use_lit = r_use_lit[i];
      issue_npc = r_npc[i];
      issue_disp = r_disp[i];
      issue_rob = r_rob[i];
      calm = r_calm[i];
      issue_valid = 1'b1;
      @(posedge clock);
      while (!issue_ready) @(posedge clock);
      if (r_mult[i] && !r_squash[i]) begin
        mult_q_val.push_back(r_value[i]);
        mult_q_rob.push_back(r_rob[i]);
        mult_q_cyc.push_back(cycle);
        mult_q_calm.push_back(r_calm[i]);
      end else if (!r_mult[i]) begin
        sc_q_val.push_back(r_value[i]);
        sc_q_rob.push_back(r_rob[i]);
      end
      if (r_rb[i]) begin
        rb_q_target.push_back(r_target[i]);
        rb_q_rob.push_back(r_rob[i]);
      end
      #2;
    end
    issue_valid = 1'b0;
    while (sc_q_val.size() != 0 || mult_q_val.size() != 0 || rb_q_target.size() != 0)
      @(posedge clock);
    repeat (10) @(posedge clock);  // Catch late stray results
    $display("Checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* fu_pkg.sv */
package fu_pkg;

  localparam int word_w       = 64;
  localparam int mult_stages  = 4;
  localparam int mult_slice_w = word_w / mult_stages;  // Multiplier bits per stage
  localparam int rob_size     = 32;

  typedef logic [word_w-1:0]           word_t;
  typedef logic [7:0]                  lit_t;
  typedef logic [20:0]                 disp_t;
  typedef logic [$clog2(rob_size)-1:0] rob_idx_t;

  // Issue opcodes
  typedef enum logic [4:0] {
    ADDQ, SUBQ, AND, BIC, BIS, ORNOT, XOR, EQV,
    SRL, SLL, SRA, CMPULT, CMPEQ, CMPULE, CMPLT, CMPLE,
    MULQ,
    BLBC, BEQ, BLT, BLE,
    BLBS, BNE, BGE, BGT,  // Negated forms
    BR, JMP
  } fu_op_t;

  typedef enum logic [3:0] {
    ALU_ADDQ,
    ALU_SUBQ,
    ALU_AND,
    ALU_BIC,
    ALU_BIS,
    ALU_ORNOT,
    ALU_XOR,
    ALU_EQV,
    ALU_SRL,
    ALU_SLL,
    ALU_SRA,
    ALU_CMPULT,
    ALU_CMPEQ,
    ALU_CMPULE,
    ALU_CMPLT,
    ALU_CMPLE
  } alu_func_t;

  typedef enum logic [1:0] {
    UNIT_ALU,
    UNIT_MULT,
    UNIT_BR
  } unit_t;

  // Entry is younger than the branch when it sits further from the ROB head
  function automatic logic rob_younger(rob_idx_t idx, rob_idx_t branch, rob_idx_t head);
    rob_idx_t dist_idx;
    rob_idx_t dist_br;
    dist_idx = idx - head;    // Wraps modulo rob_size
    dist_br  = branch - head;
    return dist_idx > dist_br;
  endfunction

endpackage

/* mult_pipeline.sv */
module mult_pipeline import fu_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     start,
  input  word_t    opa,
  input  word_t    opb,
  input  rob_idx_t rob,
  input  rob_idx_t rob_head,
  input  logic     rollback_valid,
  input  rob_idx_t rollback_rob,
  input  logic     mult_stall,
  output logic     mult_ready,
  output logic     mult_valid,
  output word_t    mult_result,
  output rob_idx_t mult_rob
);

  // Index 0 is the issue side, index i+1 the output of stage i
  logic [mult_stages-1:0] v;
  word_t                  prod_q   [mult_stages];
  word_t                  mplier_q [mult_stages];
  word_t                  mcand_q  [mult_stages];
  rob_idx_t               rob_q    [mult_stages];
  logic [mult_stages-1:0] hold;  // Last entry belongs to the completion register
  logic [mult_stages-1:0] kill;

  assign v[0]        = start;
  assign prod_q[0]   = '0;
  assign mplier_q[0] = opa;
  assign mcand_q[0]  = opb;
  assign rob_q[0]    = rob;

  for (genvar i = 0; i < mult_stages - 1; i++) begin : g_stage
    assign hold[i] = v[i+1] && hold[i+1];  // Full stage behind a frozen one
    // Test the entry this stage keeps after the edge
    assign kill[i] = rollback_valid &&
                     rob_younger(hold[i] ? rob_q[i+1] : rob_q[i], rollback_rob, rob_head);

    mult_stage stage_i (
      .clock       (clock),
      .reset       (reset),
      .hold        (hold[i]),
      .kill        (kill[i]),
      .in_valid    (v[i]),
      .in_product  (prod_q[i]),
      .in_mplier   (mplier_q[i]),
      .in_mcand    (mcand_q[i]),
      .in_rob      (rob_q[i]),
      .out_valid   (v[i+1]),
      .out_product (prod_q[i+1]),
      .out_mplier  (mplier_q[i+1]),
      .out_mcand   (mcand_q[i+1]),
      .out_rob     (rob_q[i+1])
    );
  end

  assign hold[mult_stages-1] = mult_valid && mult_stall;
  assign kill[mult_stages-1] = rollback_valid &&
      rob_younger(hold[mult_stages-1] ? mult_rob : rob_q[mult_stages-1], rollback_rob, rob_head);

  assign mult_ready = !hold[0];

  // Completion register adds the final slice
  always_ff @(posedge clock) begin
    if (reset) begin
      mult_valid <= 1'b0;
    end else if (kill[mult_stages-1]) begin
      mult_valid <= 1'b0;
    end else if (!hold[mult_stages-1]) begin
      mult_valid <= v[mult_stages-1];
    end
  end

  always_ff @(posedge clock) begin
    if (!hold[mult_stages-1]) begin
      mult_result <= prod_q[mult_stages-1] +
                     word_t'(mplier_q[mult_stages-1][mult_slice_w-1:0]) * mcand_q[mult_stages-1];
      mult_rob    <= rob_q[mult_stages-1];
    end
  end

endmodule

/* mult_stage.sv */
module mult_stage import fu_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     hold,
  input  logic     kill,
  input  logic     in_valid,
  input  word_t    in_product,
  input  word_t    in_mplier,
  input  word_t    in_mcand,
  input  rob_idx_t in_rob,
  output logic     out_valid,
  output word_t    out_product,
  output word_t    out_mplier,
  output word_t    out_mcand,
  output rob_idx_t out_rob
);

  word_t partial;

  // Low slice of the multiplier against the whole multiplicand
  assign partial = word_t'(in_mplier[mult_slice_w-1:0]) * in_mcand;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (kill) begin
      out_valid <= 1'b0;
    end else if (!hold) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (!hold) begin
      out_product <= in_product + partial;
      out_mplier  <= in_mplier >> mult_slice_w;
      out_mcand   <= in_mcand << mult_slice_w;
      out_rob     <= in_rob;
    end
  end

endmodule

/* operand_decode.sv */
module operand_decode import fu_pkg::*; (
  input  fu_op_t    op,
  input  word_t     a,
  input  word_t     b,
  input  lit_t      lit,
  input  logic      use_lit,
  input  word_t     npc,
  input  disp_t     disp,
  output unit_t     unit,
  output alu_func_t func,
  output word_t     opa,
  output word_t     opb
);

  word_t disp_ext;

  // Word displacement, sign-extended and scaled to bytes
  assign disp_ext = {{(word_w - $bits(disp_t) - 2){disp[$bits(disp_t)-1]}}, disp, 2'b00};

  always_comb begin
    unit = UNIT_ALU;
    func = ALU_ADDQ;
    opa  = a;
    opb  = use_lit ? word_t'(lit) : b;  // Literal is zero-extended
    case (op)
      ADDQ:   func = ALU_ADDQ;
      SUBQ:   func = ALU_SUBQ;
      AND:    func = ALU_AND;
      BIC:    func = ALU_BIC;
      BIS:    func = ALU_BIS;
      ORNOT:  func = ALU_ORNOT;
      XOR:    func = ALU_XOR;
      EQV:    func = ALU_EQV;
      SRL:    func = ALU_SRL;
      SLL:    func = ALU_SLL;
      SRA:    func = ALU_SRA;
      CMPULT: func = ALU_CMPULT;
      CMPEQ:  func = ALU_CMPEQ;
      CMPULE: func = ALU_CMPULE;
      CMPLT:  func = ALU_CMPLT;
      CMPLE:  func = ALU_CMPLE;
      MULQ:   unit = UNIT_MULT;
      BLBC, BEQ, BLT, BLE, BLBS, BNE, BGE, BGT, BR, JMP: begin
        unit = UNIT_BR;
        opa  = npc;       // Link value and target base
        opb  = disp_ext;
      end
      default: unit = UNIT_ALU;
    endcase
  end

endmodule

/* project.f */
fu_pkg.sv
operand_decode.sv
alu_unit.sv
branch_unit.sv
mult_stage.sv
mult_pipeline.sv
cdb_driver.sv
fu_cluster.sv
tb_clock_gen.sv
fu_cluster_tb.sv

/* tb_clock_gen.sv */
module tb_clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clock);
    #2 reset = 1'b0;
  end

endmodule
